//--- filelist.f
common/cnn_pkg.sv
design/pixel_loader.sv
conv/conv_scan.sv
conv/conv_mac.sv
pool/pool_scan.sv
design/cnn_top.sv
testbench/cnn_assert.sv
testbench/cnn_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = cnn_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/cnn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_tb import cnn_pkg::*;
();

    localparam int timeout_cycles = 2000;
    localparam int ref_kernel [9] = '{1, 2, 1, 0, -4, 0, -1, 2, -1};

    logic   clk;
    logic   rst;
    logic   in_req;
    pixel_t in_data;
    logic   in_ack;
    logic   out_req;
    acc_t   out_data;
    logic   out_ack;
    logic   busy;

    int    frame [n_pix];
    int    expected [n_out];
    string test_name;
    int    value_errors;
    int    protocol_errors;
    int    timeout_errors;
    logic  hold_ack_low;
    int    next_first;

    cnn_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack),
        .busy     (busy)
    );

    initial clk = 1'b0;

    always #10 clk = ~clk;

    // A held request must not be acked while the previous frame is still out
    always @(negedge clk)
    begin
        if (hold_ack_low)
        begin
            assert (!in_ack)
            else
            begin
                protocol_errors++;
                $display("FAIL %s: expected in_ack %0d, actual %0d", test_name, 0, in_ack);
            end
        end
    end

    task automatic finish_run();
        int assert_errors;
        assert_errors = dut0.assert0.fail_count;
        $display("Errors: value %0d, protocol %0d, timeout %0d, assertion %0d",
                 value_errors, protocol_errors, timeout_errors, assert_errors);
        if (value_errors + protocol_errors + timeout_errors + assert_errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("Timed out in test %s while waiting for %s", test_name, what);
    endtask

    // Convolution over every valid window followed by 2x2 max
    task automatic compute_expected();
        int feat [conv_w][conv_w];
        int s;
        int m;
        for (int r = 0; r < conv_w; r++)
        begin
            for (int c = 0; c < conv_w; c++)
            begin
                s = 0;
                for (int i = 0; i < k_w; i++)
                begin
                    for (int j = 0; j < k_w; j++)
                    begin
                        s += frame[(r + i) * img_w + c + j] * ref_kernel[i * k_w + j];
                    end
                end
                feat[r][c] = s;
            end
        end
        for (int p = 0; p < pool_w; p++)
        begin
            for (int q = 0; q < pool_w; q++)
            begin
                m = feat[2 * p][2 * q];
                m = (feat[2 * p][2 * q + 1] > m) ? feat[2 * p][2 * q + 1] : m;
                m = (feat[2 * p + 1][2 * q] > m) ? feat[2 * p + 1][2 * q] : m;
                m = (feat[2 * p + 1][2 * q + 1] > m) ? feat[2 * p + 1][2 * q + 1] : m;
                expected[p * pool_w + q] = m;
            end
        end
    endtask

    task automatic fill_random();
        for (int k = 0; k < n_pix; k++)
        begin
            frame[k] = int'($urandom_range(15)) - 8;
        end
    endtask

    // Called and returns one step after a rising edge
    task automatic send_pixel(input int value);
        int count;
        in_data = pixel_t'(value);
        in_req  = 1'b1;
        count   = 0;
        while (!in_ack && count < timeout_cycles)
        begin
            @(posedge clk);
            #1;
            count++;
        end
        if (!in_ack)
        begin
            report_timeout("in_ack to rise");
            return;
        end
        in_req = 1'b0;
        count  = 0;
        while (in_ack && count < timeout_cycles)
        begin
            @(posedge clk);
            #1;
            count++;
        end
        if (in_ack)
        begin
            report_timeout("in_ack to fall");
            return;
        end
    endtask

    task automatic send_frame();
        for (int k = 0; k < n_pix && timeout_errors == 0; k++)
        begin
            send_pixel(frame[k]);
        end
    endtask

    task automatic receive_output(input int idx, input int max_delay);
        int count;
        int delay;
        count = 0;
        while (!out_req && count < timeout_cycles)
        begin
            @(posedge clk);
            #1;
            count++;
        end
        if (!out_req)
        begin
            report_timeout("out_req to rise");
            return;
        end
        assert (out_data == acc_t'(expected[idx]))
        else
        begin
            value_errors++;
            $display("FAIL %s: expected %0d, actual %0d", test_name, expected[idx], out_data);
        end
        delay = int'($urandom_range(max_delay));
        repeat (delay) @(posedge clk);
        #1 out_ack = 1'b1;
        count = 0;
        while (out_req && count < timeout_cycles)
        begin
            @(posedge clk);
            #1;
            count++;
        end
        if (out_req)
        begin
            report_timeout("out_req to fall");
            return;
        end
        delay = int'($urandom_range(max_delay));
        repeat (delay) @(posedge clk);
        #1 out_ack = 1'b0;
    endtask

    task automatic receive_frame(input int max_delay);
        for (int i = 0; i < n_out && timeout_errors == 0; i++)
        begin
            receive_output(i, max_delay);
        end
    endtask

    initial
    begin
        void'($urandom(31573));
        value_errors    = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        hold_ack_low    = 1'b0;
        rst     = 1'b1;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        assert (!in_ack && !out_req && !busy)
        else
        begin
            value_errors++;
            $display("FAIL %s: expected in_ack out_req busy 000, actual %b%b%b",
                     test_name, in_ack, out_req, busy);
        end

        test_name = "random_frame";
        fill_random();
        compute_expected();
        send_frame();
        receive_frame(0);

        test_name = "out_backpressure";
        fill_random();
        compute_expected();
        send_frame();
        receive_frame(5);

        // Second frame's first pixel waits while the first frame drains
        test_name = "in_backpressure";
        fill_random();
        compute_expected();
        send_frame();
        next_first   = int'($urandom_range(15)) - 8;
        in_data      = pixel_t'(next_first);
        in_req       = 1'b1;
        hold_ack_low = 1'b1;
        receive_frame(3);
        hold_ack_low = 1'b0;
        fill_random();
        frame[0] = next_first;
        compute_expected();
        send_frame();
        receive_frame(2);

        test_name = "all_negative";
        for (int k = 0; k < n_pix; k++)
        begin
            frame[k] = -8;
        end
        compute_expected();
        send_frame();
        receive_frame(1);

        test_name = "checkerboard";
        for (int k = 0; k < n_pix; k++)
        begin
            frame[k] = ((k / img_w + k % img_w) % 2 == 0) ? 7 : -8;
        end
        compute_expected();
        send_frame();
        receive_frame(1);

        finish_run();
    end

endmodule

`default_nettype wire

//--- testbench/cnn_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_assert import cnn_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic in_req,
    input wire logic in_ack,
    input wire logic out_req,
    input wire logic out_ack,
    input wire acc_t out_data
);

    int fail_count = 0;

    // Loader answers the source on the input side
    in_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
    else
    begin
        fail_count++;
        $error("in_ack rose while in_req was low");
    end

    in_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(in_ack) |-> !$past(in_req))
    else
    begin
        fail_count++;
        $error("in_ack fell before in_req was dropped");
    end

    // Output request and data held until the sink acks
    out_req_hold: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> out_req && $stable(out_data))
    else
    begin
        fail_count++;
        $error("out_req or out_data changed before out_ack");
    end

    out_req_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(out_req) |-> $past(out_ack))
    else
    begin
        fail_count++;
        $error("out_req fell without out_ack");
    end

endmodule

bind cnn_top cnn_assert assert0 (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
);

`default_nettype wire

//--- design/cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_top import cnn_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   in_req,
    input  wire pixel_t in_data,
    output logic        in_ack,
    output logic        out_req,
    output acc_t        out_data,
    input  wire logic   out_ack,
    output logic        busy
);

    pix_addr_t pix_addr;
    pixel_t    pix_data;
    logic      frame_loaded;
    logic      frame_released;
    tap_t      tap;
    acc_t      sum;
    logic      sum_valid;
    map_addr_t map_addr;
    acc_t      map_data;
    logic      map_done;

    pixel_loader loader0 (
        .clk            (clk),
        .rst            (rst),
        .in_req         (in_req),
        .in_data        (in_data),
        .in_ack         (in_ack),
        .pix_addr       (pix_addr),
        .pix_data       (pix_data),
        .frame_loaded   (frame_loaded),
        .busy           (busy),
        .frame_released (frame_released)
    );

    conv_scan scan0 (
        .clk          (clk),
        .rst          (rst),
        .frame_loaded (frame_loaded),
        .pix_addr     (pix_addr),
        .pix_data     (pix_data),
        .tap          (tap),
        .sum          (sum),
        .sum_valid    (sum_valid),
        .map_addr     (map_addr),
        .map_data     (map_data),
        .map_done     (map_done)
    );

    conv_mac mac0 (
        .clk       (clk),
        .rst       (rst),
        .tap       (tap),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    pool_scan pool0 (
        .clk            (clk),
        .rst            (rst),
        .map_done       (map_done),
        .map_addr       (map_addr),
        .map_data       (map_data),
        .out_req        (out_req),
        .out_data       (out_data),
        .out_ack        (out_ack),
        .frame_released (frame_released)
    );

endmodule

`default_nettype wire

//--- pool/pool_scan.sv
`timescale 1ns/1ps
`default_nettype none

module pool_scan import cnn_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic map_done,
    output map_addr_t map_addr,
    input  wire acc_t map_data,
    output logic      out_req,
    output acc_t      out_data,
    input  wire logic out_ack,
    output logic      frame_released
);

    typedef enum logic [1:0] {ps_idle, ps_read, ps_req, ps_drop} ps_state_t;

    ps_state_t  state;
    tap_idx_t   blk_idx;
    tap_idx_t   blk_row;
    tap_idx_t   blk_col;
    logic [1:0] sub;
    logic       sample;

    // Entry sub of the current 2x2 block
    always_comb
    begin
        blk_row  = tap_idx_t'(blk_idx / pool_w);
        blk_col  = tap_idx_t'(blk_idx % pool_w);
        map_addr = map_addr_t'((2 * blk_row + sub[1]) * conv_w + 2 * blk_col + sub[0]);
    end

    // Entry 0 is already addressed while idle, so it is read on map_done
    assign sample = (state == ps_read) || (state == ps_idle && map_done);

    // Running signed max held through the output handshake
    always_ff @(posedge clk)
    begin
        if (sample && (sub == 2'd0 || map_data > out_data))
        begin
            out_data <= map_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= ps_idle;
            blk_idx        <= '0;
            sub            <= '0;
            out_req        <= 1'b0;
            frame_released <= 1'b0;
        end
        else
        begin
            frame_released <= 1'b0;
            if (sample)
            begin
                sub <= sub + 1'b1;
            end
            case (state)
                ps_idle:
                begin
                    if (map_done)
                    begin
                        state <= ps_read;
                    end
                end
                ps_read:
                begin
                    if (sub == 2'd3)
                    begin
                        out_req <= 1'b1;
                        state   <= ps_req;
                    end
                end
                ps_req:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        state   <= ps_drop;
                    end
                end
                ps_drop:
                begin
                    // Handshake done once the sink drops its ack
                    if (!out_ack)
                    begin
                        if (blk_idx == tap_idx_t'(n_out - 1))
                        begin
                            blk_idx        <= '0;
                            frame_released <= 1'b1;
                            state          <= ps_idle;
                        end
                        else
                        begin
                            blk_idx <= blk_idx + 1'b1;
                            state   <= ps_read;
                        end
                    end
                end
                default: state <= ps_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- conv/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mac import cnn_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire tap_t tap,
    output acc_t      sum,
    output logic      sum_valid
);

    acc_t acc;
    acc_t product;
    logic last_tap;

    // Both operands sign-extended before the multiply
    always_comb
    begin
        product  = acc_t'(tap.pixel) * acc_t'(conv_kernel[tap.idx]);
        last_tap = tap.valid && (tap.idx == tap_idx_t'(n_taps - 1));
    end

    always_ff @(posedge clk)
    begin
        if (tap.valid)
        begin
            // Tap 0 starts a new window
            if (tap.idx == '0)
            begin
                acc <= product;
            end
            else
            begin
                acc <= acc + product;
            end
        end
        if (last_tap)
        begin
            sum <= acc + product;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sum_valid <= 1'b0;
        end
        else
        begin
            sum_valid <= last_tap;
        end
    end

endmodule

`default_nettype wire

//--- conv/conv_scan.sv
`timescale 1ns/1ps
`default_nettype none

module conv_scan import cnn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      frame_loaded,
    output pix_addr_t      pix_addr,
    input  wire pixel_t    pix_data,
    output tap_t           tap,
    input  wire acc_t      sum,
    input  wire logic      sum_valid,
    input  wire map_addr_t map_addr,
    output acc_t           map_data,
    output logic           map_done
);

    typedef enum logic {cs_idle, cs_run} cs_state_t;

    cs_state_t  state;
    logic [2:0] win_row;
    logic [2:0] win_col;
    tap_idx_t   tap_idx;
    tap_idx_t   k_row;
    tap_idx_t   k_col;
    pix_addr_t  win_base;
    logic       issue;
    map_addr_t  wr_ptr;
    acc_t       map_mem [conv_w * conv_w];

    // Window base plus the kernel offset of the current tap
    always_comb
    begin
        k_row    = tap_idx_t'(tap_idx / k_w);
        k_col    = tap_idx_t'(tap_idx % k_w);
        win_base = pix_addr_t'(win_row * img_w + win_col);
        pix_addr = win_base + pix_addr_t'(k_row * img_w + k_col);
    end

    // First tap goes out on the same edge that sees frame_loaded
    assign issue = (state == cs_run) || frame_loaded;

    always_ff @(posedge clk)
    begin
        tap.idx   <= tap_idx;
        tap.pixel <= pix_data;
        if (rst)
        begin
            state     <= cs_idle;
            win_row   <= '0;
            win_col   <= '0;
            tap_idx   <= '0;
            tap.valid <= 1'b0;
        end
        else
        begin
            tap.valid <= issue;
            if (issue)
            begin
                state <= cs_run;
                if (tap_idx == tap_idx_t'(n_taps - 1))
                begin
                    tap_idx <= '0;
                    // Skip to the next row once the window reaches the right edge
                    if (win_col == 3'(conv_w - 1))
                    begin
                        win_col <= '0;
                        if (win_row == 3'(conv_w - 1))
                        begin
                            win_row <= '0;
                            state   <= cs_idle;
                        end
                        else
                        begin
                            win_row <= win_row + 1'b1;
                        end
                    end
                    else
                    begin
                        win_col <= win_col + 1'b1;
                    end
                end
                else
                begin
                    tap_idx <= tap_idx + 1'b1;
                end
            end
        end
    end

    // Feature map filled in window order
    always_ff @(posedge clk)
    begin
        if (sum_valid)
        begin
            map_mem[wr_ptr] <= sum;
        end
    end

    assign map_data = map_mem[map_addr];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            map_done <= 1'b0;
        end
        else
        begin
            map_done <= 1'b0;
            if (sum_valid)
            begin
                if (wr_ptr == map_addr_t'(conv_w * conv_w - 1))
                begin
                    wr_ptr   <= '0;
                    map_done <= 1'b1;
                end
                else
                begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pixel_loader.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_loader import cnn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      in_req,
    input  wire pixel_t    in_data,
    output logic           in_ack,
    input  wire pix_addr_t pix_addr,
    output pixel_t         pix_data,
    output logic           frame_loaded,
    output logic           busy,
    input  wire logic      frame_released
);

    typedef enum logic {ld_wait_req, ld_wait_drop} ld_state_t;

    ld_state_t state;
    pix_addr_t wr_ptr;
    logic      full;
    pixel_t    img_mem [n_pix];

    // Image memory read asynchronously by the convolution scanner
    always_ff @(posedge clk)
    begin
        if (state == ld_wait_req && in_req && !full)
        begin
            img_mem[wr_ptr] <= in_data;
        end
    end

    assign pix_data = img_mem[pix_addr];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= ld_wait_req;
            wr_ptr       <= '0;
            full         <= 1'b0;
            busy         <= 1'b0;
            in_ack       <= 1'b0;
            frame_loaded <= 1'b0;
        end
        else
        begin
            frame_loaded <= 1'b0;
            if (frame_released)
            begin
                full <= 1'b0;
                busy <= 1'b0;
            end
            case (state)
                ld_wait_req:
                begin
                    // A full frame holds off the source until it is released
                    if (in_req && !full)
                    begin
                        in_ack <= 1'b1;
                        busy   <= 1'b1;
                        state  <= ld_wait_drop;
                    end
                end
                ld_wait_drop:
                begin
                    if (!in_req)
                    begin
                        in_ack <= 1'b0;
                        wr_ptr <= wr_ptr + 1'b1;
                        state  <= ld_wait_req;
                        if (wr_ptr == pix_addr_t'(n_pix - 1))
                        begin
                            full         <= 1'b1;
                            frame_loaded <= 1'b1;
                        end
                    end
                end
                default: state <= ld_wait_req;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // Frame and kernel geometry
    localparam int img_w  = 8;
    localparam int k_w    = 3;
    localparam int conv_w = img_w - k_w + 1;
    localparam int pool_w = conv_w / 2;

    localparam int n_pix  = img_w * img_w;
    localparam int n_taps = k_w * k_w;
    localparam int n_out  = pool_w * pool_w;

    typedef logic signed [3:0]  pixel_t;
    typedef logic signed [3:0]  weight_t;

    // Wide enough for 9 taps of 8 by 8 in either sign
    typedef logic signed [11:0] acc_t;

    typedef logic [5:0] pix_addr_t;
    typedef logic [5:0] map_addr_t;
    typedef logic [3:0] tap_idx_t;

    // Edge kernel in row-major order
    localparam weight_t conv_kernel [n_taps] = '{
        4'sd1,  4'sd2, 4'sd1,
        4'sd0, -4'sd4, 4'sd0,
        -4'sd1, 4'sd2, -4'sd1
    };

    // One pixel on its way into the accumulator
    typedef struct packed {
        logic     valid;
        tap_idx_t idx;
        pixel_t   pixel;
    } tap_t;

endpackage

`default_nettype wire
